// ==== common/ntm_gate_defines.svh ====
// Activation gate widths, register offsets and tanh segment constants
`ifndef NTM_GATE_DEFINES_SVH
`define NTM_GATE_DEFINES_SVH

////////////////////
// Widths

`define NTM_DATA_WIDTH 16    // Q4.12 weight or activation
`define NTM_ACC_WIDTH  40    // Q16.24 accumulator
`define NTM_SIZE_WIDTH 8     // Each count register

////////////////////
// Register map

`define NTM_REG_CTRL   32'h00
`define NTM_REG_STATUS 32'h04
`define NTM_REG_SIZE_X 32'h08
`define NTM_REG_SIZE_K 32'h0C
`define NTM_REG_SIZE_L 32'h10

////////////////////
// Tanh segments in Q4.12

`define NTM_TANH_KNEE_LO 2048  // 0.5
`define NTM_TANH_KNEE_HI 6144  // 1.5
`define NTM_TANH_ONE     4096  // 1.0

`endif

// ==== common/ntm_gate_pkg.sv ====
// Shared types of the activation gate: beat word, pipeline records and AXI4-Lite bundles
`default_nettype none

`include "ntm_gate_defines.svh"

package ntm_gate_pkg;

  // W/x, K/r or U/h pair in one beat
  typedef struct packed {
    logic signed [`NTM_DATA_WIDTH-1:0] weight;  // Upper half
    logic signed [`NTM_DATA_WIDTH-1:0] act;     // Lower half
  } operand_pair_t;

  // One stream word, read by row position
  typedef union packed {
    operand_pair_t      pair;
    logic signed [31:0] bias;  // Q8.24
  } beat_word_u;

  // Sequencer to mac
  typedef struct packed {
    logic       valid;
    logic       is_bias;  // Last beat of the row
    beat_word_u word;
  } mac_beat_t;

  // Mac to tanh
  typedef struct packed {
    logic                             valid;
    logic signed [`NTM_ACC_WIDTH-1:0] sum;
  } row_sum_t;

  // Operand counts per row
  typedef struct packed {
    logic [`NTM_SIZE_WIDTH-1:0] size_x;
    logic [`NTM_SIZE_WIDTH-1:0] size_k;
    logic [`NTM_SIZE_WIDTH-1:0] size_l;
  } size_cfg_t;

  // AXI4-Lite master side
  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // AXI4-Lite slave side
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/ntm_gate_regs.sv ====
// AXI4-Lite register block holding the gate sizes with start, busy and done
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_gate_regs (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire ntm_gate_pkg::axil_req_t axil_req,
  output ntm_gate_pkg::axil_rsp_t      axil_rsp,
  output ntm_gate_pkg::size_cfg_t      cfg,
  output logic                         start,
  input  wire logic                    busy,
  input  wire logic                    run_done
);

  localparam int SW = `NTM_SIZE_WIDTH;

  logic        wr_ready_q;  // Shared awready/wready
  logic        bvalid_q;
  logic        arready_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_mux;
  logic        done_q;
  logic        start_q;
  logic        wr_fire;
  logic        wr_en;
  logic        ar_fire;

  logic [SW-1:0] size_x_q;
  logic [SW-1:0] size_k_q;
  logic [SW-1:0] size_l_q;

  ////////////////////
  // Handshakes

  assign wr_fire = wr_ready_q && axil_req.awvalid && axil_req.wvalid;
  assign wr_en   = wr_fire && axil_req.wstrb[0];  // All fields in byte 0
  assign ar_fire = arready_q && axil_req.arvalid;

  assign axil_rsp = '{
    awready: wr_ready_q,
    wready:  wr_ready_q,
    bresp:   2'b00,  // OKAY
    bvalid:  bvalid_q,
    arready: arready_q,
    rdata:   rdata_q,
    rresp:   2'b00,  // OKAY
    rvalid:  rvalid_q
  };

  assign cfg   = '{size_x: size_x_q, size_k: size_k_q, size_l: size_l_q};
  assign start = start_q;

  ////////////////////
  // Write side

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      start_q    <= 1'b0;
      size_x_q   <= '0;
      size_k_q   <= '0;
      size_l_q   <= '0;
    end else begin
      // Accept AW and W only as a pair for one cycle
      wr_ready_q <= axil_req.awvalid && axil_req.wvalid && !wr_ready_q && !bvalid_q;

      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;  // Response taken
      end

      // Start pulse the cycle after the handshake
      start_q <= wr_en && (axil_req.awaddr == `NTM_REG_CTRL) &&
                 axil_req.wdata[0] && !busy && !start_q;

      if (wr_en && !busy) begin  // Sizes frozen during a run
        case (axil_req.awaddr)
          `NTM_REG_SIZE_X: size_x_q <= axil_req.wdata[SW-1:0];
          `NTM_REG_SIZE_K: size_k_q <= axil_req.wdata[SW-1:0];
          `NTM_REG_SIZE_L: size_l_q <= axil_req.wdata[SW-1:0];
          default: ;
        endcase
      end
    end
  end

  // Sticky done
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done_q <= 1'b0;
    end else if (run_done) begin
      done_q <= 1'b1;  // Wins over start for an empty run
    end else if (start_q) begin
      done_q <= 1'b0;
    end
  end

  ////////////////////
  // Read side

  always_comb begin
    case (axil_req.araddr)
      `NTM_REG_STATUS: rd_mux = {30'b0, done_q, busy};
      `NTM_REG_SIZE_X: rd_mux = 32'(size_x_q);
      `NTM_REG_SIZE_K: rd_mux = 32'(size_k_q);
      `NTM_REG_SIZE_L: rd_mux = 32'(size_l_q);
      default:         rd_mux = '0;  // CTRL reads back zero
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= axil_req.arvalid && !arready_q && !rvalid_q;
      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ar_fire) begin
      rdata_q <= rd_mux;  // Captured at address handshake
    end
  end

  // Write response held until the master takes it
  a_bvalid_hold: assert property (@(posedge CLK) disable iff (RST)
    bvalid_q && !axil_req.bready |=> bvalid_q);

endmodule

`default_nettype wire

// ==== activation_gate/ntm_gate_sequencer.sv ====
// Beat sequencer counting pairs and rows, marking the bias beat and pacing it against the output
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_gate_sequencer (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire ntm_gate_pkg::size_cfg_t  cfg,
  input  wire logic                     start,
  output logic                          busy,
  output logic                          run_done,
  input  wire ntm_gate_pkg::beat_word_u in_word,
  input  wire logic                     in_valid,
  output logic                          in_ready,
  output ntm_gate_pkg::mac_beat_t       beat,
  input  wire logic                     result_taken
);

  localparam int SW    = `NTM_SIZE_WIDTH;
  localparam int CNT_W = SW + 2;  // Holds three counts summed

  logic                     busy_q;
  logic                     pending_q;  // Row result not yet taken
  logic [CNT_W-1:0]         beat_cnt_q;
  logic [SW-1:0]            row_cnt_q;  // Bias beats accepted
  logic [CNT_W-1:0]         pair_total;
  logic                     at_bias;
  logic                     rows_fed;
  logic                     fire;
  logic                     beat_valid_q;
  logic                     beat_bias_q;
  ntm_gate_pkg::beat_word_u beat_word_q;

  ////////////////////
  // Row position

  // Pairs per row before the bias
  assign pair_total = CNT_W'(cfg.size_x) + CNT_W'(cfg.size_k) + CNT_W'(cfg.size_l);
  assign at_bias    = (beat_cnt_q == pair_total);
  assign rows_fed   = (row_cnt_q == cfg.size_l);  // Every bias in

  // Bias waits while the previous result sits at the output
  assign in_ready = busy_q && !rows_fed && !(at_bias && pending_q);
  assign fire     = in_valid && in_ready;

  // Empty run ends at once or else on the last result taken
  assign run_done = (start && (cfg.size_l == '0)) ||
                    (busy_q && result_taken && rows_fed);

  assign busy = busy_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q     <= 1'b0;
      pending_q  <= 1'b0;
      beat_cnt_q <= '0;
      row_cnt_q  <= '0;
    end else if (start) begin
      busy_q     <= (cfg.size_l != '0);
      pending_q  <= 1'b0;
      beat_cnt_q <= '0;
      row_cnt_q  <= '0;
    end else begin
      if (run_done) begin
        busy_q <= 1'b0;
      end

      if (fire) begin
        if (at_bias) begin
          beat_cnt_q <= '0;  // Next row
          row_cnt_q  <= row_cnt_q + 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
        end
      end

      if (fire && at_bias) begin
        pending_q <= 1'b1;
      end else if (result_taken) begin
        pending_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Beat forwarding

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      beat_valid_q <= 1'b0;
      beat_bias_q  <= 1'b0;
    end else begin
      beat_valid_q <= fire;
      beat_bias_q  <= at_bias;  // Decides pair or bias reading
    end
  end

  always_ff @(posedge CLK) begin
    if (fire) begin
      beat_word_q <= in_word;
    end
  end

  assign beat = '{valid: beat_valid_q, is_bias: beat_bias_q, word: beat_word_q};

  // Stream open only inside a run and within the row and run counts
  a_ready_in_run: assert property (@(posedge CLK) disable iff (RST)
    in_ready |-> busy_q && (row_cnt_q < cfg.size_l) && (beat_cnt_q <= pair_total));

endmodule

`default_nettype wire

// ==== activation_gate/ntm_gate_mac.sv ====
// Two-stage multiply-accumulate forming one row sum per bias beat
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_gate_mac (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire ntm_gate_pkg::mac_beat_t beat,
  output ntm_gate_pkg::row_sum_t       sum
);

  localparam int ACC_W = `NTM_ACC_WIDTH;

  logic                    s1_valid_q;
  logic                    s1_bias_q;
  logic signed [31:0]      s1_val_q;  // Q8.24 product or bias
  logic signed [31:0]      product;
  logic signed [ACC_W-1:0] s1_ext;
  logic signed [ACC_W-1:0] acc_q;
  logic signed [ACC_W-1:0] acc_next;

  ////////////////////
  // Stage 1

  // Q4.12 x Q4.12 gives Q8.24
  assign product = $signed(beat.word.pair.weight) * $signed(beat.word.pair.act);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid_q <= 1'b0;
      s1_bias_q  <= 1'b0;
    end else begin
      s1_valid_q <= beat.valid;
      s1_bias_q  <= beat.is_bias;
    end
  end

  always_ff @(posedge CLK) begin
    if (beat.valid) begin
      // Same word read as bias at row end
      s1_val_q <= beat.is_bias ? beat.word.bias : product;
    end
  end

  ////////////////////
  // Stage 2

  assign s1_ext   = {{(ACC_W-32){s1_val_q[31]}}, s1_val_q};  // Sign extend
  assign acc_next = acc_q + s1_ext;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q <= '0;
    end else if (s1_valid_q) begin
      if (s1_bias_q) begin
        acc_q <= '0;  // Fresh row
      end else begin
        acc_q <= acc_next;
      end
    end
  end

  // Completed row straight off the adder, registered by tanh
  assign sum = '{valid: s1_valid_q && s1_bias_q, sum: acc_next};

endmodule

`default_nettype wire

// ==== activation_gate/ntm_gate_tanh.sv ====
// Piecewise-linear tanh on the row sum with an output register held under back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_gate_tanh (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire ntm_gate_pkg::row_sum_t sum,
  output logic [`NTM_DATA_WIDTH-1:0]  out_data,
  output logic                        out_valid,
  input  wire logic                   out_ready,
  output logic                        result_taken
);

  localparam int ACC_W = `NTM_ACC_WIDTH;
  localparam int DW    = `NTM_DATA_WIDTH;
  localparam int SH_W  = ACC_W - 12;  // Width after the shift

  localparam logic signed [SH_W-1:0] Y_MAX = (1 <<< (DW-1)) - 1;
  localparam logic signed [SH_W-1:0] Y_MIN = -(1 <<< (DW-1));
  localparam logic [DW:0] KNEE_LO = `NTM_TANH_KNEE_LO;
  localparam logic [DW:0] KNEE_HI = `NTM_TANH_KNEE_HI;
  localparam logic [DW:0] ONE     = `NTM_TANH_ONE;

  logic signed [SH_W-1:0] shifted;
  logic signed [DW-1:0]   y;
  logic [DW:0]            mag;  // One extra bit for -32768
  logic [DW:0]            seg;
  logic signed [DW-1:0]   res;

  ////////////////////
  // Saturate and segment

  always_comb begin
    shifted = sum.sum[ACC_W-1:12];  // Arithmetic shift by 12, Q8.24 to Q4.12

    if (shifted > Y_MAX) begin
      y = {1'b0, {(DW-1){1'b1}}};
    end else if (shifted < Y_MIN) begin
      y = {1'b1, {(DW-1){1'b0}}};
    end else begin
      y = shifted[DW-1:0];
    end

    mag = y[DW-1] ? -{y[DW-1], y} : {1'b0, y};

    if (mag < KNEE_LO) begin
      seg = mag;  // Linear near zero
    end else if (mag < KNEE_HI) begin
      seg = KNEE_LO + ((mag - KNEE_LO) >> 1);  // Half slope
    end else begin
      seg = ONE;  // Flat tail
    end

    res = y[DW-1] ? -seg[DW-1:0] : seg[DW-1:0];  // Odd function
  end

  ////////////////////
  // Output hold

  assign result_taken = out_valid && out_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (sum.valid) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // New sum only arrives once the sequencer sees the old one taken
  always_ff @(posedge CLK) begin
    if (sum.valid) begin
      out_data <= res;
    end
  end

  a_out_stable: assert property (@(posedge CLK) disable iff (RST)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== hdl/ntm_activation_gate.sv ====
// Activation gate top: register block feeding the sequencer, mac and tanh pipeline
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_activation_gate (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire ntm_gate_pkg::axil_req_t  axil_req,
  output ntm_gate_pkg::axil_rsp_t       axil_rsp,
  input  wire ntm_gate_pkg::beat_word_u in_word,
  input  wire logic                     in_valid,
  output logic                          in_ready,
  output logic [`NTM_DATA_WIDTH-1:0]    out_data,
  output logic                          out_valid,
  input  wire logic                     out_ready
);

  ntm_gate_pkg::size_cfg_t cfg;
  logic                    start;
  logic                    busy;
  logic                    run_done;
  logic                    result_taken;  // Tanh back to sequencer
  ntm_gate_pkg::mac_beat_t beat;
  ntm_gate_pkg::row_sum_t  sum;

  ////////////////////
  // Configuration

  ntm_gate_regs i_regs (
    .CLK      (CLK),
    .RST      (RST),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .start    (start),
    .busy     (busy),
    .run_done (run_done)
  );

  ////////////////////
  // Gate pipeline

  ntm_gate_sequencer i_sequencer (
    .CLK          (CLK),
    .RST          (RST),
    .cfg          (cfg),
    .start        (start),
    .busy         (busy),
    .run_done     (run_done),
    .in_word      (in_word),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .beat         (beat),
    .result_taken (result_taken)
  );

  ntm_gate_mac i_mac (
    .CLK  (CLK),
    .RST  (RST),
    .beat (beat),
    .sum  (sum)
  );

  ntm_gate_tanh i_tanh (
    .CLK          (CLK),
    .RST          (RST),
    .sum          (sum),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .result_taken (result_taken)
  );

endmodule

`default_nettype wire

// ==== testbench/ntm_activation_gate_tb.sv ====
// Testbench for the activation gate with directed register, stream and back-pressure tests
`timescale 1ns/1ps
`default_nettype none

`include "ntm_gate_defines.svh"

module ntm_activation_gate_tb;

  localparam int TIMEOUT_CYCLES = 60;  // Per wait loop

  // Signals that wait_for can poll
  localparam int SEL_AWREADY   = 0;
  localparam int SEL_BVALID    = 1;
  localparam int SEL_ARREADY   = 2;
  localparam int SEL_RVALID    = 3;
  localparam int SEL_IN_READY  = 4;
  localparam int SEL_OUT_VALID = 5;

  logic                     CLK;
  logic                     RST;
  ntm_gate_pkg::axil_req_t  axil_req;
  ntm_gate_pkg::axil_rsp_t  axil_rsp;
  ntm_gate_pkg::beat_word_u in_word;
  logic                     in_valid;
  logic                     in_ready;
  logic [15:0]              out_data;
  logic                     out_valid;
  logic                     out_ready;

  int          errors;
  int          checks;
  logic [31:0] lfsr_state;
  int          row_w [0:15];  // Weights of the row being sent
  int          row_a [0:15];  // Activations of the row being sent

  ntm_activation_gate i_dut (
    .CLK       (CLK),
    .RST       (RST),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #50 CLK = ~CLK;  // 100 ns period

  ////////////////////
  // Reference and stimulus helpers

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit, then sign extend
  task automatic draw_signed(input int nbits, output int val);
    logic [31:0] raw;
    int          i;
    raw = '0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      raw = {raw[30:0], lfsr_state[0]};
    end
    val = raw[nbits-1] ? int'(raw) - (1 << nbits) : int'(raw);
  endtask

  // Expected Q4.12 output of the current row arrays
  function automatic int model_gate(input int n_pairs, input int bias);
    longint acc;
    longint y;
    longint m;
    longint seg;
    int     i;
    acc = bias;  // Q8.24, sign extended
    for (i = 0; i < n_pairs; i++) begin
      acc = acc + longint'(row_w[i]) * longint'(row_a[i]);
    end
    y = acc >>> 12;  // Back to Q4.12
    if (y > 32767) begin
      y = 32767;
    end else if (y < -32768) begin
      y = -32768;
    end
    m = (y < 0) ? -y : y;
    if (m < `NTM_TANH_KNEE_LO) begin
      seg = m;
    end else if (m < `NTM_TANH_KNEE_HI) begin
      seg = `NTM_TANH_KNEE_LO + ((m - `NTM_TANH_KNEE_LO) >> 1);
    end else begin
      seg = `NTM_TANH_ONE;
    end
    return int'((y < 0) ? -seg : seg);
  endfunction

  task automatic check(input longint got, input longint exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s, got %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_AWREADY:  return axil_rsp.awready;
      SEL_BVALID:   return axil_rsp.bvalid;
      SEL_ARREADY:  return axil_rsp.arready;
      SEL_RVALID:   return axil_rsp.rvalid;
      SEL_IN_READY: return in_ready;
      default:      return out_valid;
    endcase
  endfunction

  // Polls at falling edges so the transfer lands on the next rising edge
  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    @(negedge CLK);
    while (!probe(sel) && n < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      n++;
    end
    if (!probe(sel)) begin
      errors++;
      $display("Timed out at %0d ns waiting for %s", $time, what);
    end
  endtask

  ////////////////////
  // Bus and stream tasks

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    wait_for(SEL_AWREADY, "write address and data accept");
    check(axil_rsp.wready, 1, "wready together with awready");
    @(posedge CLK);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    wait_for(SEL_BVALID, "write response");
    check(axil_rsp.bresp, 0, "write response OKAY");
    @(posedge CLK);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    wait_for(SEL_ARREADY, "read address accept");
    @(posedge CLK);
    #1;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    wait_for(SEL_RVALID, "read data");
    data = axil_rsp.rdata;  // Stable at the falling edge
    check(axil_rsp.rresp, 0, "read response OKAY");
    @(posedge CLK);
    #1;
    axil_req.rready = 1'b0;
  endtask

  // Program sizes, start, then confirm STATUS
  task automatic start_run(input int x, input int k, input int l);
    logic [31:0] st;
    axil_write(`NTM_REG_SIZE_X, x);
    axil_write(`NTM_REG_SIZE_K, k);
    axil_write(`NTM_REG_SIZE_L, l);
    axil_write(`NTM_REG_CTRL, 32'h1);
    axil_read(`NTM_REG_STATUS, st);
    check(st, (l != 0) ? 1 : 2, "STATUS after start");  // Empty run ends at once
  endtask

  task automatic send_beat(input ntm_gate_pkg::beat_word_u w);
    in_word  = w;
    in_valid = 1'b1;  // Stays high for back-to-back beats
    wait_for(SEL_IN_READY, "in_ready");
    @(posedge CLK);
    #1;
  endtask

  task automatic send_row(input int n_pairs, input int bias, input bit with_bias);
    ntm_gate_pkg::beat_word_u w;
    int                       i;
    for (i = 0; i < n_pairs; i++) begin
      w.pair.weight = 16'(row_w[i]);
      w.pair.act    = 16'(row_a[i]);
      send_beat(w);
    end
    if (with_bias) begin
      w.bias = bias;  // Same word read as Q8.24
      send_beat(w);
    end
    in_valid = 1'b0;
  endtask

  // Check the held result, then take it with a one-cycle out_ready
  task automatic expect_out(input int exp, input string what);
    wait_for(SEL_OUT_VALID, what);
    check($signed(out_data), exp, what);
    @(posedge CLK);
    #1;
    out_ready = 1'b1;
    @(posedge CLK);
    #1;
    out_ready = 1'b0;
  endtask

  ////////////////////
  // Directed tests

  task automatic reset_values;
    logic [31:0] rd;
    axil_read(`NTM_REG_STATUS, rd);
    check(rd, 0, "STATUS after reset");
    axil_read(`NTM_REG_SIZE_X, rd);
    check(rd, 0, "SIZE_X after reset");
    axil_read(`NTM_REG_SIZE_K, rd);
    check(rd, 0, "SIZE_K after reset");
    axil_read(`NTM_REG_SIZE_L, rd);
    check(rd, 0, "SIZE_L after reset");
    axil_write(`NTM_REG_SIZE_X, 5);
    axil_write(`NTM_REG_SIZE_K, 6);
    axil_write(`NTM_REG_SIZE_L, 7);
    axil_read(`NTM_REG_SIZE_X, rd);
    check(rd, 5, "SIZE_X readback");
    axil_read(`NTM_REG_SIZE_K, rd);
    check(rd, 6, "SIZE_K readback");
    axil_read(`NTM_REG_SIZE_L, rd);
    check(rd, 7, "SIZE_L readback");
  endtask

  task automatic empty_run;
    start_run(0, 0, 0);  // Done checked inside
    repeat (6) begin
      @(negedge CLK);
      check(out_valid, 0, "out_valid on empty run");
      check(in_ready, 0, "in_ready on empty run");
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic single_row_timing;
    logic [31:0] rd;
    int          bias;
    // 0.75 - 0.125 + 1.0 - 0.25 + 0.5 bias lands on the flat tail
    row_w[0] = 4096;
    row_a[0] = 3072;
    row_w[1] = 2048;
    row_a[1] = -1024;
    row_w[2] = 8192;
    row_a[2] = 2048;
    row_w[3] = -4096;
    row_a[3] = 1024;
    bias = 1 << 23;
    start_run(2, 1, 1);
    send_row(4, bias, 1'b1);  // Returns just after the bias transfer
    @(negedge CLK);
    check(out_valid, 0, "out_valid 1 cycle after bias");
    @(negedge CLK);
    check(out_valid, 0, "out_valid 2 cycles after bias");
    @(negedge CLK);
    check(out_valid, 1, "out_valid 3 cycles after bias");
    expect_out(model_gate(4, bias), "single row result");
    axil_read(`NTM_REG_STATUS, rd);
    check(rd, 2, "STATUS after single row");
  endtask

  task automatic random_rows;
    logic [31:0] rd;
    int          bias_q24 [0:2];
    int          r;
    int          i;
    bias_q24[0] = 1 << 22;         // +0.25 in the linear segment
    bias_q24[1] = -(1 << 24);      // -1.0 in the half-slope segment
    bias_q24[2] = 40 * (1 << 24);  // +40.0 saturates y
    start_run(3, 2, 3);
    for (r = 0; r < 3; r++) begin
      for (i = 0; i < 8; i++) begin
        draw_signed(10, row_w[i]);  // Within +-0.125
        draw_signed(10, row_a[i]);
      end
      send_row(8, bias_q24[r], 1'b1);
      expect_out(model_gate(8, bias_q24[r]), $sformatf("random row %0d", r));
    end
    axil_read(`NTM_REG_STATUS, rd);
    check(rd, 2, "STATUS after random rows");
  endtask

  task automatic back_pressure;
    ntm_gate_pkg::beat_word_u w;
    logic [31:0]              rd;
    logic [15:0]              held;
    int                       bias0;
    int                       bias1;
    int                       exp0;
    int                       exp1;
    int                       i;
    start_run(1, 1, 2);
    for (i = 0; i < 4; i++) begin
      draw_signed(12, row_w[i]);
      draw_signed(12, row_a[i]);
    end
    draw_signed(24, bias0);
    exp0 = model_gate(4, bias0);
    send_row(4, bias0, 1'b1);
    wait_for(SEL_OUT_VALID, "row 0 result");
    held = out_data;
    check($signed(held), exp0, "row 0 result");
    @(posedge CLK);
    #1;

    // Sizes frozen while the run waits
    axil_write(`NTM_REG_SIZE_X, 9);
    axil_read(`NTM_REG_SIZE_X, rd);
    check(rd, 1, "SIZE_X write while busy");
    axil_read(`NTM_REG_STATUS, rd);
    check(rd, 1, "STATUS while result waits");

    for (i = 0; i < 4; i++) begin
      draw_signed(12, row_w[i]);
      draw_signed(12, row_a[i]);
    end
    draw_signed(24, bias1);
    exp1 = model_gate(4, bias1);
    send_row(4, bias1, 1'b0);  // Pairs still flow
    w.bias   = bias1;
    in_word  = w;
    in_valid = 1'b1;
    repeat (4) begin
      @(negedge CLK);
      check(in_ready, 0, "in_ready at held bias beat");
      check(out_valid, 1, "out_valid under back-pressure");
      check(out_data, held, "out_data under back-pressure");
    end
    @(posedge CLK);
    #1;
    out_ready = 1'b1;  // Release row 0
    @(posedge CLK);
    #1;
    out_ready = 1'b0;
    send_beat(w);
    in_valid = 1'b0;
    expect_out(exp1, "row 1 result after release");
    axil_read(`NTM_REG_STATUS, rd);
    check(rd, 2, "STATUS after back-pressure run");
  endtask

  ////////////////////
  // Sequence

  initial begin
    CLK        = 1'b0;
    RST        = 1'b1;
    axil_req   = '0;
    in_word    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'hb862;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;

    reset_values();
    empty_run();
    single_row_timing();
    random_rows();
    back_pressure();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ntm_activation_gate.f ====
+incdir+common
common/ntm_gate_pkg.sv
hdl/ntm_gate_regs.sv
activation_gate/ntm_gate_sequencer.sv
activation_gate/ntm_gate_mac.sv
activation_gate/ntm_gate_tanh.sv
hdl/ntm_activation_gate.sv
testbench/ntm_activation_gate_tb.sv
